/* list.f */
+incdir+source
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
verif/rv_checker.sv
verif/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps -f list.f \
  --top-module tb_rv_core --Mdir obj_dir -o sim_tb_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
exit 1

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_rv_core;

  // Memory depths and run length
  localparam int IMEM_WORDS   = 256;
  localparam int DMEM_WORDS   = 64;
  localparam int PROG_LEN     = 200;
  localparam int RESET_CYCLES = 8;
  localparam int MARGIN       = 50;
  localparam int CLK_PERIOD   = 100;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_raddr;
  logic [31:0]         imem_rdata;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic                dmem_ren;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                dmem_we;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic                ebreak;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  integer      seed;
  int          error_count;
  int          check_count;
  logic        done;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Memory models
  //--------------------------------------------------------------------------
  // Combinational reads, word indexed
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  // Store lands at the rising edge
  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  rv_core i_rv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_ren   (dmem_ren),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

  rv_checker #(.IMEM_WORDS(IMEM_WORDS)) i_rv_checker (
    .clk         (clk),
    .rst         (rst),
    .prog        (imem),
    .imem_raddr  (imem_raddr),
    .dmem_addr   (dmem_addr),
    .dmem_ren    (dmem_ren),
    .dmem_we     (dmem_we),
    .dmem_wdata  (dmem_wdata),
    .ebreak      (ebreak),
    .error_count (error_count),
    .check_count (check_count),
    .done        (done)
  );

  //--------------------------------------------------------------------------
  // Instruction encoders
  //--------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    encode_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2);
    // Base register always x0
    encode_s = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    encode_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
    encode_j = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  //--------------------------------------------------------------------------
  // Random program, EBREAK in the last word
  //--------------------------------------------------------------------------
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] target;
    int          hop;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r   = next_random();
      r2  = next_random();
      rd  = r[4:0];
      rs1 = r[9:5];
      rs2 = r[14:10];
      f3  = r[17:15];
      // Forward hop of 1..4, clipped at EBREAK
      hop = 1 + int'(r[19:18]);
      if (i + hop > PROG_LEN - 1) begin
        hop = PROG_LEN - 1 - i;
      end
      case (int'(r[31:28]))
        0, 1, 2: begin
          f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r2[0], 5'b0} : 7'b0;
          imem[i] = {f7, rs2, rs1, f3, rd, 7'h33};
        end
        3, 4, 5: begin
          if (f3 == 3'b001) begin
            imm = {7'b0, r2[4:0]};
          end else if (f3 == 3'b101) begin
            imm = {1'b0, r2[5], 5'b0, r2[4:0]};
          end else begin
            imm = r2[11:0];
          end
          imem[i] = encode_i(imm, rs1, f3, rd, 7'h13);
        end
        6:  imem[i] = {r2[31:12], rd, 7'h37};
        7:  imem[i] = {r2[31:12], rd, 7'h17};
        8:  imem[i] = encode_i({4'b0, r2[5:0], 2'b00}, 5'd0, 3'b010, rd, 7'h03);
        12: begin
          // Map reserved 010/011 onto BLTU/BGEU
          f3 = r2[2:0];
          if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = {1'b1, f3[1:0]};
          end
          imem[i] = encode_b(13'(hop * 4), rs2, rs1, f3);
        end
        13: imem[i] = encode_j(21'(hop * 4), rd);
        14: begin
          // Absolute target from x0, bit 0 sometimes set
          target  = 32'((i + hop) * 4);
          imem[i] = encode_i(target[11:0] | {11'b0, r2[0]}, 5'd0, 3'b000, rd, 7'h67);
        end
        default: imem[i] = encode_s({4'b0, r2[5:0], 2'b00}, rs2);
      endcase
    end
    imem[PROG_LEN-1] = 32'h0010_0073;
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------
  initial begin
    rst  = 1'b1;
    seed = 83;
    // Unused words hold NOPs tagged with their index
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = encode_i(12'(i), 5'd0, 3'b000, 5'd0, 7'h13);
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h9e37_79b9 * 32'(i * 4 + 1);
    end
    build_program();
    // Count reset cycles on rising edges, release on the falling edge after
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (done);
    @(negedge clk);
    $display("Run finished: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from program length
  initial begin
    #((PROG_LEN + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: core did not halt on EBREAK within %0d cycles",
             PROG_LEN + RESET_CYCLES + MARGIN);
    $display("Run aborted: %0d checks, %0d errors", check_count, error_count);
    $display("Test failed");
    $finish;
  end

endmodule

/* verif/rv_checker.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_checker #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         prog [IMEM_WORDS],
  input  logic [`RV_XLEN-1:0] imem_raddr,
  input  logic [`RV_XLEN-1:0] dmem_addr,
  input  logic                dmem_ren,
  input  logic                dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_wdata,
  input  logic                ebreak,
  output int                  error_count,
  output int                  check_count,
  output logic                done
);

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // ISA model state
  logic [31:0] x [32];
  logic [31:0] mem [64];
  logic [31:0] pc;
  logic        rst_seen;
  int          halt_cycles;

  initial begin
    error_count = 0;
    check_count = 0;
    done        = 1'b0;
    rst_seen    = 1'b0;
    halt_cycles = 0;
    pc          = `RV_RESET_PC;
    // Same initial image as the data memory
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h9e37_79b9 * 32'(i * 4 + 1);
    end
  end

  task automatic compare_port(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Integer ops by funct3, alt picks SUB or SRA
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    alu_model = res;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  branch_model = (a == b);
      3'b001:  branch_model = (a != b);
      3'b100:  branch_model = ($signed(a) < $signed(b));
      3'b101:  branch_model = ($signed(a) >= $signed(b));
      3'b110:  branch_model = (a < b);
      3'b111:  branch_model = (a >= b);
      default: branch_model = 1'b0;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // One instruction per cycle, ports checked before the model retires it
  //--------------------------------------------------------------------------
  task automatic step_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        wr;
    logic        store;
    logic        halt;
    ins     = prog[pc[9:2]];
    a       = x[ins[19:15]];
    b       = x[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u   = {ins[31:12], 12'h000};
    imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = pc + 32'd4;
    res     = '0;
    wr      = 1'b0;
    store   = 1'b0;
    halt    = 1'b0;
    compare_port("imem_raddr", pc, imem_raddr);
    case (ins[6:0])
      7'h33: begin
        res = alu_model(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      7'h13: begin
        // No SUBI, bit 30 only matters for SRAI
        res = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
        wr  = 1'b1;
      end
      7'h37: begin
        res = imm_u;
        wr  = 1'b1;
      end
      7'h17: begin
        res = pc + imm_u;
        wr  = 1'b1;
      end
      7'h03: begin
        addr = a + imm_i;
        compare_port("dmem_ren", 32'd1, 32'(dmem_ren));
        compare_port("dmem_addr", addr, dmem_addr);
        res = mem[addr[7:2]];
        wr  = 1'b1;
      end
      7'h23: begin
        addr  = a + imm_s;
        store = 1'b1;
        compare_port("dmem_we", 32'd1, 32'(dmem_we));
        compare_port("dmem_addr", addr, dmem_addr);
        compare_port("dmem_wdata", b, dmem_wdata);
        mem[addr[7:2]] = b;
      end
      7'h63: begin
        if (branch_model(ins[14:12], a, b)) begin
          next_pc = pc + imm_b;
        end
      end
      7'h6f: begin
        res     = pc + 32'd4;
        wr      = 1'b1;
        next_pc = pc + imm_j;
      end
      7'h67: begin
        res     = pc + 32'd4;
        wr      = 1'b1;
        next_pc = (a + imm_i) & ~32'd1;
      end
      7'h73: halt = (ins == EBREAK_WORD);
      default: ;
    endcase
    if (!store) begin
      compare_port("dmem_we", 32'd0, 32'(dmem_we));
    end
    compare_port("ebreak", 32'(halt), 32'(ebreak));
    // Halted core keeps fetching the same EBREAK
    if (halt) begin
      next_pc = pc;
      halt_cycles++;
      if (halt_cycles >= 4) begin
        done = 1'b1;
      end
    end
    if (wr && ins[11:7] != 5'd0) begin
      x[ins[11:7]] = res;
    end
    pc = next_pc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      // First reset edge loads the PC, checks start after it
      if (rst_seen) begin
        compare_port("imem_raddr", `RV_RESET_PC, imem_raddr);
        compare_port("dmem_we", 32'd0, 32'(dmem_we));
        compare_port("dmem_ren", 32'd0, 32'(dmem_ren));
        compare_port("ebreak", 32'd0, 32'(ebreak));
      end
      rst_seen    = 1'b1;
      pc          = `RV_RESET_PC;
      halt_cycles = 0;
      for (int i = 0; i < 32; i++) begin
        x[i] = '0;
      end
    end else begin
      step_model();
    end
  end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,

  // Instruction fetch, combinational read
  output logic [`RV_XLEN-1:0] imem_raddr,
  input  logic [31:0]         imem_rdata,

  // Data memory
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic                dmem_ren,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                dmem_we,
  output logic [`RV_XLEN-1:0] dmem_wdata,

  output logic                ebreak
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0]  pc;
  logic [`RV_XLEN-1:0]  pc_plus4;
  logic [`RV_XLEN-1:0]  pc_next;

  // Decode outputs
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic                  reg_write;
  logic                  mem_read;
  logic                  mem_write;
  logic                  is_branch;
  logic                  is_jump;
  logic                  is_jalr;
  logic                  is_ebreak;
  logic                  alu_b_imm;
  alu_a_src_e            alu_a_src;
  alu_op_e               alu_op;
  res_src_e              res_src;
  logic [2:0]            funct3;
  logic [`RV_XLEN-1:0]   imm;

  // Register file and execute
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   jb_target;
  logic                  branch_taken;
  logic [`RV_XLEN-1:0]   rd_data;

  //--------------------------------------------------------------------------
  // Fetch
  //--------------------------------------------------------------------------
  assign imem_raddr = pc;
  assign pc_plus4   = pc + `RV_XLEN'(4);

  // Redirect on jumps and taken branches
  // EBREAK parks the PC until reset
  always_comb begin
    if (is_ebreak) begin
      pc_next = pc;
    end else if (is_jump || (is_branch && branch_taken)) begin
      pc_next = jb_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  //--------------------------------------------------------------------------
  // Decode, register read, execute
  //--------------------------------------------------------------------------
  rv_decode i_rv_decode (
    .instr     (imem_rdata),
    .rst       (rst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .is_ebreak (is_ebreak),
    .alu_b_imm (alu_b_imm),
    .alu_a_src (alu_a_src),
    .alu_op    (alu_op),
    .res_src   (res_src),
    .funct3    (funct3),
    .imm       (imm)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rd_en    (reg_write),
    .rd_addr  (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_rv_execute (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .imm          (imm),
    .alu_a_src    (alu_a_src),
    .alu_b_imm    (alu_b_imm),
    .alu_op       (alu_op),
    .funct3       (funct3),
    .is_jalr      (is_jalr),
    .alu_result   (alu_result),
    .jb_target    (jb_target),
    .branch_taken (branch_taken)
  );

  //--------------------------------------------------------------------------
  // Memory access and write-back
  //--------------------------------------------------------------------------
  // Word access only, address straight from the ALU
  assign dmem_addr  = alu_result;
  assign dmem_ren   = mem_read;
  assign dmem_we    = mem_write;
  assign dmem_wdata = rs2_data;

  always_comb begin
    case (res_src)
      RES_MEM:      rd_data = dmem_rdata;
      RES_PC_PLUS4: rd_data = pc_plus4;
      default:      rd_data = alu_result;
    endcase
  end

  // Stays high while halted since the PC holds on EBREAK
  assign ebreak = is_ebreak;

endmodule

/* source/rv_execute.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] imm,
  input  rv_pkg::alu_a_src_e  alu_a_src,
  input  logic                alu_b_imm,
  input  rv_pkg::alu_op_e     alu_op,
  input  logic [2:0]          funct3,
  input  logic                is_jalr,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] jb_target,
  output logic                branch_taken
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [4:0]          shamt;

  //--------------------------------------------------------------------------
  // Operand select
  //--------------------------------------------------------------------------
  always_comb begin
    case (alu_a_src)
      ALU_A_ZERO: alu_a = '0;
      ALU_A_PC:   alu_a = pc;
      default:    alu_a = rs1_data;
    endcase
  end

  assign alu_b = alu_b_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  //--------------------------------------------------------------------------
  // ALU
  //--------------------------------------------------------------------------
  always_comb begin
    case (alu_op)
      ALU_SUB:  alu_result = alu_a - alu_b;
      ALU_SLL:  alu_result = alu_a << shamt;
      ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:  alu_result = alu_a ^ alu_b;
      ALU_SRL:  alu_result = alu_a >> shamt;
      ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> shamt);
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      default:  alu_result = alu_a + alu_b;
    endcase
  end

  //--------------------------------------------------------------------------
  // Branch compare on raw register values
  //--------------------------------------------------------------------------
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (rs1_data == rs2_data);
      3'b001:  branch_taken = (rs1_data != rs2_data);
      3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  branch_taken = (rs1_data < rs2_data);
      3'b111:  branch_taken = (rs1_data >= rs2_data);
      // Reserved encodings never branch
      default: branch_taken = 1'b0;
    endcase
  end

  // JALR target is rs1 + imm with bit 0 dropped
  // JAL and branches are PC relative
  assign jb_target = is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc + imm;

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic                  rd_en,
  input  logic [`RV_REG_AW-1:0] rd_addr,
  input  logic [`RV_XLEN-1:0]   rd_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  // Single write port, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational reads
  // x0 hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_decode (
  input  logic [31:0]            instr,
  input  logic                   rst,
  output logic [`RV_REG_AW-1:0]  rs1,
  output logic [`RV_REG_AW-1:0]  rs2,
  output logic [`RV_REG_AW-1:0]  rd,
  output logic                   reg_write,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   is_branch,
  output logic                   is_jump,
  output logic                   is_jalr,
  output logic                   is_ebreak,
  output logic                   alu_b_imm,
  output rv_pkg::alu_a_src_e     alu_a_src,
  output rv_pkg::alu_op_e        alu_op,
  output rv_pkg::res_src_e       res_src,
  output logic [2:0]             funct3,
  output logic [`RV_XLEN-1:0]    imm
);
  import rv_pkg::*;

  // Only SYSTEM encoding acted on
  localparam logic [31:0] I_EBREAK = 32'h0010_0073;

  opcode_e             opcode;
  imm_type_e           imm_type;
  alu_op_e             func_op;
  logic                funct7_b5;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  // Fixed instruction fields
  assign opcode    = opcode_e'(instr[6:0]);
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30];

  //--------------------------------------------------------------------------
  // ALU function from funct3 / funct7
  //--------------------------------------------------------------------------
  always_comb begin
    case (funct3)
      // SUB exists only in register-register form
      3'b000:  func_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  func_op = ALU_SLL;
      3'b010:  func_op = ALU_SLT;
      3'b011:  func_op = ALU_SLTU;
      3'b100:  func_op = ALU_XOR;
      // SRAI shares the funct7 bit with SRA
      3'b101:  func_op = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  func_op = ALU_OR;
      default: func_op = ALU_AND;
    endcase
  end

  //--------------------------------------------------------------------------
  // Control decode
  //--------------------------------------------------------------------------
  always_comb begin
    // No-op defaults, also used for unknown opcodes
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    alu_b_imm = 1'b0;
    alu_a_src = ALU_A_RS1;
    alu_op    = ALU_ADD;
    res_src   = RES_ALU;
    imm_type  = IMM_I;

    case (opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        alu_op    = func_op;
      end
      OPC_OP_IMM: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_op    = func_op;
      end
      OPC_LUI: begin
        reg_write = 1'b1;
        alu_a_src = ALU_A_ZERO;
        alu_b_imm = 1'b1;
        imm_type  = IMM_U;
      end
      OPC_AUIPC: begin
        reg_write = 1'b1;
        alu_a_src = ALU_A_PC;
        alu_b_imm = 1'b1;
        imm_type  = IMM_U;
      end
      OPC_LOAD: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_b_imm = 1'b1;
        res_src   = RES_MEM;
      end
      OPC_STORE: begin
        mem_write = 1'b1;
        alu_b_imm = 1'b1;
        imm_type  = IMM_S;
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        imm_type  = IMM_B;
      end
      OPC_JAL: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        res_src   = RES_PC_PLUS4;
        imm_type  = IMM_J;
      end
      OPC_JALR: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        is_jalr   = 1'b1;
        alu_b_imm = 1'b1;
        res_src   = RES_PC_PLUS4;
      end
      // ECALL and CSR ops fall through as no-ops
      OPC_SYSTEM: is_ebreak = (instr == I_EBREAK);
      default: ;
    endcase

    // Nothing commits while in reset
    if (rst) begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      is_ebreak = 1'b0;
    end
  end

  //--------------------------------------------------------------------------
  // Immediates
  //--------------------------------------------------------------------------
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  always_comb begin
    case (imm_type)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  // Major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU functions
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // First ALU operand
  typedef enum logic [1:0] {ALU_A_RS1, ALU_A_ZERO, ALU_A_PC} alu_a_src_e;

  // Immediate encodings
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;

  // Write-back source
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_PLUS4} res_src_e;

endpackage

/* source/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

//--------------------------------------------------------------------------
// Core dimensions
//--------------------------------------------------------------------------

// Data path and address width
`define RV_XLEN 32

// Architectural registers x0..x31
`define RV_REG_COUNT 32

// Register specifier width
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
